// ==== hw/xcorr_pkg.sv ====
package xcorr_pkg;

  // Sample and product widths
  localparam int SAMP_W = 18;                  // Real or imag part of a sample
  localparam int PROD_W = 2 * SAMP_W + 1;      // Sum of two 36-bit products
  localparam int ACC_W  = 48;                  // Default accumulator width

  // AXI4-Lite bus widths
  localparam int AXI_AW = 8;
  localparam int AXI_DW = 32;

  // Controller states, also read back through REG_STATUS
  typedef enum logic [1:0] {
    IDLE  = 2'd0,                              // Timer and accumulators held clear
    ACCUM = 2'd1,                              // Adding products
    DUMP  = 2'd2                               // One-cycle bank update
  } vacc_state_e;

  // Register map, byte offsets of 32-bit words
  localparam logic [AXI_AW-1:0] REG_CTRL     = 8'h00;  // Bit 0 enable
  localparam logic [AXI_AW-1:0] REG_ACC_LEN  = 8'h04;  // Products per dump
  localparam logic [AXI_AW-1:0] REG_STATUS   = 8'h08;  // State and dump count
  localparam logic [AXI_AW-1:0] REG_RES_BASE = 8'h10;  // Eight result words
  localparam logic [AXI_AW-1:0] RES_SPAN     = 8'h20;  // Bytes in result window

  // Reset value of the accumulation length
  localparam logic [AXI_DW-1:0] ACC_LEN_RST = 32'd4;

endpackage

// ==== hw/xprod_if.sv ====
`timescale 1ns/1ns

// Both slots' conjugate products, one beat per app_clk cycle
interface xprod_if;

  logic                                valid;  // Products valid this cycle
  logic signed [xcorr_pkg::PROD_W-1:0] p0_r;   // Slot 0 real
  logic signed [xcorr_pkg::PROD_W-1:0] p0_i;   // Slot 0 imag
  logic signed [xcorr_pkg::PROD_W-1:0] p1_r;   // Slot 1 real
  logic signed [xcorr_pkg::PROD_W-1:0] p1_i;   // Slot 1 imag

  modport src (output valid, p0_r, p0_i, p1_r, p1_i);  // Multiplier side
  modport dst (input valid, p0_r, p0_i, p1_r, p1_i);   // Accumulator side
  modport mon (input valid);                           // Controller only needs valid

endinterface

// ==== hw/cmult_conj_2x.sv ====
`timescale 1ns/1ns

module cmult_conj_2x (
  input  logic                              app_clk,
  input  logic                              dsp_clk_i,
  input  logic                              rst_n_i,
  input  logic                              sample_valid_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0a_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0a_i_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1a_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1a_i_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0b_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0b_i_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1b_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1b_i_i,
  xprod_if.src                              prod_o
);

  localparam int SW = xcorr_pkg::SAMP_W;
  localparam int PW = xcorr_pkg::PROD_W;
  localparam int MW = 2 * SW;                    // Single product width

  logic signed [SW-1:0] a0_r_q, a0_i_q, a1_r_q, a1_i_q;  // Antenna A, app domain
  logic signed [SW-1:0] b0_r_q, b0_i_q, b1_r_q, b1_i_q;  // Antenna B, app domain
  logic                 phase;                   // 0 first half of app cycle, 1 second
  logic signed [SW-1:0] s1_ar, s1_ai, s1_br, s1_bi;      // Muxed operands
  logic signed [MW-1:0] m_rr, m_ii, m_ir, m_ri;          // Partial products
  logic signed [PW-1:0] res_r, res_i;            // Adder stage
  logic signed [PW-1:0] hold0_r, hold0_i;        // Slot 0 result
  logic signed [PW-1:0] hold1_r, hold1_i;        // Slot 1 result
  logic [2:0]           vld_sr;                  // Tracks samples in flight

  always_ff @(posedge app_clk) begin
    a0_r_q <= in0a_r_i;
    a0_i_q <= in0a_i_i;
    a1_r_q <= in1a_r_i;
    a1_i_q <= in1a_i_i;
    b0_r_q <= in0b_r_i;
    b0_i_q <= in0b_i_i;
    b1_r_q <= in1b_r_i;
    b1_i_q <= in1b_i_i;
  end

  // Reset release lands on an app edge, so phase is 0 after every app-aligned edge
  always_ff @(posedge dsp_clk_i) begin
    if (!rst_n_i) begin
      phase <= 1'b0;
    end else begin
      phase <= ~phase;
    end
  end

  always_ff @(posedge dsp_clk_i) begin
    s1_ar <= phase ? a1_r_q : a0_r_q;            // Slot 0 taken mid-cycle
    s1_ai <= phase ? a1_i_q : a0_i_q;
    s1_br <= phase ? b1_r_q : b0_r_q;            // Slot 1 taken on app edge
    s1_bi <= phase ? b1_i_q : b0_i_q;
    m_rr  <= s1_ar * s1_br;
    m_ii  <= s1_ai * s1_bi;
    m_ir  <= s1_ai * s1_br;
    m_ri  <= s1_ar * s1_bi;
    res_r <= {m_rr[MW-1], m_rr} + {m_ii[MW-1], m_ii};  // ar*br + ai*bi
    res_i <= {m_ir[MW-1], m_ir} - {m_ri[MW-1], m_ri};  // ai*br - ar*bi
  end

  // Adder output alternates slot 0 and slot 1, split by phase
  always_ff @(posedge dsp_clk_i) begin
    if (phase) begin
      hold0_r <= res_r;                          // Slot 0 sits in res before app edge
      hold0_i <= res_i;
    end else begin
      hold1_r <= res_r;                          // Slot 1 sits in res before mid edge
      hold1_i <= res_i;
    end
  end

  always_ff @(posedge app_clk) begin
    prod_o.p0_r <= hold0_r;                      // Back into app domain
    prod_o.p0_i <= hold0_i;
    prod_o.p1_r <= hold1_r;
    prod_o.p1_i <= hold1_i;
  end

  always_ff @(posedge app_clk) begin
    if (!rst_n_i) begin
      vld_sr       <= '0;
      prod_o.valid <= 1'b0;
    end else begin
      vld_sr       <= {vld_sr[1:0], sample_valid_i};
      prod_o.valid <= vld_sr[2];                 // Three edges after input capture
    end
  end

endmodule

// ==== hw/acc_len_timer.sv ====
`timescale 1ns/1ns

module acc_len_timer (
  input  logic                          app_clk,
  input  logic                          rst_n_i,
  input  logic                          count_en_i,  // One per accepted product
  input  logic                          clear_i,     // Held in idle
  input  logic [xcorr_pkg::AXI_DW-1:0]  acc_len_i,
  output logic                          last_o       // Next counted product ends integration
);

  localparam int DW = xcorr_pkg::AXI_DW;

  logic [DW-1:0] len_eff;                        // Length with zero mapped to one
  logic [DW-1:0] cnt_q;                          // Products so far in this integration

  assign len_eff = (acc_len_i == '0) ? {{(DW-1){1'b0}}, 1'b1} : acc_len_i;
  assign last_o  = (cnt_q == len_eff - 1'b1);

  always_ff @(posedge app_clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (clear_i) begin
      cnt_q <= '0;
    end else if (count_en_i) begin
      if (last_o) begin
        cnt_q <= '0;                             // Wrap for the next integration
      end else begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

endmodule

// ==== hw/vacc_ctrl.sv ====
`timescale 1ns/1ns

module vacc_ctrl (
  input  logic                    app_clk,
  input  logic                    rst_n_i,
  input  logic                    enable_i,     // From REG_CTRL
  xprod_if.mon                    prod_i,
  input  logic                    last_i,       // From length timer
  output logic                    count_en_o,
  output logic                    clear_o,
  output logic                    acc_en_o,
  output logic                    dump_o,
  output xcorr_pkg::vacc_state_e  state_o,
  output logic [15:0]             dump_cnt_o
);

  xcorr_pkg::vacc_state_e state_q;
  xcorr_pkg::vacc_state_e state_d;
  logic                   run;                  // Accumulating or dumping
  logic                   end_of_int;           // Last product of integration seen

  assign run        = (state_q == xcorr_pkg::ACCUM) || (state_q == xcorr_pkg::DUMP);
  assign end_of_int = prod_i.valid && last_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      xcorr_pkg::IDLE: begin
        if (enable_i) state_d = xcorr_pkg::ACCUM;
      end
      xcorr_pkg::ACCUM: begin
        if (!enable_i) begin
          state_d = xcorr_pkg::IDLE;            // Partial sum dropped
        end else if (end_of_int) begin
          state_d = xcorr_pkg::DUMP;
        end
      end
      xcorr_pkg::DUMP: begin
        if (!enable_i) begin
          state_d = xcorr_pkg::IDLE;
        end else if (end_of_int) begin
          state_d = xcorr_pkg::DUMP;            // Length of one dumps every product
        end else begin
          state_d = xcorr_pkg::ACCUM;
        end
      end
      default: state_d = xcorr_pkg::IDLE;
    endcase
  end

  always_ff @(posedge app_clk) begin
    if (!rst_n_i) begin
      state_q    <= xcorr_pkg::IDLE;
      dump_cnt_o <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == xcorr_pkg::DUMP) begin
        dump_cnt_o <= dump_cnt_o + 1'b1;        // Counts with the bank update
      end
    end
  end

  // Products keep flowing through the dump cycle
  assign count_en_o = prod_i.valid && run;
  assign acc_en_o   = prod_i.valid && run;
  assign clear_o    = (state_q == xcorr_pkg::IDLE);
  assign dump_o     = (state_q == xcorr_pkg::DUMP);
  assign state_o    = state_q;

endmodule

// ==== hw/vector_acc.sv ====
`timescale 1ns/1ns

module vector_acc #(
  parameter int ACC_W = xcorr_pkg::ACC_W
) (
  input  logic                    app_clk,
  input  logic                    rst_n_i,
  xprod_if.dst                    prod_i,
  input  logic                    acc_en_i,
  input  logic                    dump_i,
  input  logic                    clr_i,
  output logic signed [ACC_W-1:0] bank_o [4]    // 0-real, 0-imag, 1-real, 1-imag
);

  localparam int PW = xcorr_pkg::PROD_W;

  logic signed [ACC_W-1:0] acc_q [4];           // Running sums, wrap on overflow
  logic signed [ACC_W-1:0] ext [4];             // Sign-extended products

  assign ext[0] = {{(ACC_W-PW){prod_i.p0_r[PW-1]}}, prod_i.p0_r};
  assign ext[1] = {{(ACC_W-PW){prod_i.p0_i[PW-1]}}, prod_i.p0_i};
  assign ext[2] = {{(ACC_W-PW){prod_i.p1_r[PW-1]}}, prod_i.p1_r};
  assign ext[3] = {{(ACC_W-PW){prod_i.p1_i[PW-1]}}, prod_i.p1_i};

  always_ff @(posedge app_clk) begin
    if (!rst_n_i) begin
      for (int k = 0; k < 4; k++) begin
        acc_q[k]  <= '0;
        bank_o[k] <= '0;
      end
    end else if (clr_i) begin
      for (int k = 0; k < 4; k++) begin
        acc_q[k] <= '0;                         // Idle keeps the sums empty
      end
    end else if (dump_i) begin
      for (int k = 0; k < 4; k++) begin
        bank_o[k] <= acc_q[k];                  // Finished integration
        acc_q[k]  <= prod_i.valid ? ext[k] : '0; // Next one starts with no gap
      end
    end else if (acc_en_i) begin
      for (int k = 0; k < 4; k++) begin
        acc_q[k] <= acc_q[k] + ext[k];
      end
    end
  end

endmodule

// ==== hw/axil_csr.sv ====
`timescale 1ns/1ns

module axil_csr #(
  parameter int ACC_W = xcorr_pkg::ACC_W
) (
  input  logic                          app_clk,
  input  logic                          rst_n_i,
  input  logic                          s_axil_awvalid_i,
  input  logic [xcorr_pkg::AXI_AW-1:0]  s_axil_awaddr_i,
  input  logic                          s_axil_wvalid_i,
  input  logic [xcorr_pkg::AXI_DW-1:0]  s_axil_wdata_i,
  input  logic                          s_axil_bready_i,
  output logic                          s_axil_awready_o,
  output logic                          s_axil_wready_o,
  output logic                          s_axil_bvalid_o,
  input  logic                          s_axil_arvalid_i,
  input  logic [xcorr_pkg::AXI_AW-1:0]  s_axil_araddr_i,
  input  logic                          s_axil_rready_i,
  output logic                          s_axil_arready_o,
  output logic                          s_axil_rvalid_o,
  output logic [xcorr_pkg::AXI_DW-1:0]  s_axil_rdata_o,
  input  xcorr_pkg::vacc_state_e        state_i,
  input  logic [15:0]                   dump_cnt_i,
  input  logic signed [ACC_W-1:0]       bank_i [4],
  output logic                          enable_o,
  output logic [xcorr_pkg::AXI_DW-1:0]  acc_len_o
);

  localparam int AW = xcorr_pkg::AXI_AW;
  localparam int DW = xcorr_pkg::AXI_DW;

  logic [AW-1:0]   aw_word;                     // Word-aligned write address
  logic [AW-1:0]   ar_word;                     // Word-aligned read address
  logic [AW-1:0]   res_off;                     // Offset into result window
  logic [2*DW-1:0] res_ext;                     // Selected result, sign-extended
  logic [DW-1:0]   rd_word;                     // Decoded read data
  logic            aw_start;                    // Both write channels presented

  assign aw_word  = {s_axil_awaddr_i[AW-1:2], 2'b00};
  assign ar_word  = {s_axil_araddr_i[AW-1:2], 2'b00};
  assign res_off  = ar_word - xcorr_pkg::REG_RES_BASE;
  assign res_ext  = {{(2*DW-ACC_W){bank_i[res_off[4:3]][ACC_W-1]}}, bank_i[res_off[4:3]]};
  assign aw_start = s_axil_awvalid_i && s_axil_wvalid_i && !s_axil_awready_o && !s_axil_bvalid_o;

  always_comb begin
    rd_word = '0;                               // Unmapped reads return zero
    if (ar_word == xcorr_pkg::REG_CTRL) begin
      rd_word = {{(DW-1){1'b0}}, enable_o};
    end else if (ar_word == xcorr_pkg::REG_ACC_LEN) begin
      rd_word = acc_len_o;
    end else if (ar_word == xcorr_pkg::REG_STATUS) begin
      rd_word = {dump_cnt_i, 14'd0, state_i};
    end else if ((ar_word >= xcorr_pkg::REG_RES_BASE) &&
                 (ar_word < xcorr_pkg::REG_RES_BASE + xcorr_pkg::RES_SPAN)) begin
      rd_word = res_off[2] ? res_ext[2*DW-1:DW] : res_ext[DW-1:0];  // High or low word
    end
  end

  // Write channel
  always_ff @(posedge app_clk) begin
    if (!rst_n_i) begin
      s_axil_awready_o <= 1'b0;
      s_axil_wready_o  <= 1'b0;
      s_axil_bvalid_o  <= 1'b0;
      enable_o         <= 1'b0;
      acc_len_o        <= xcorr_pkg::ACC_LEN_RST;
    end else begin
      s_axil_awready_o <= aw_start;             // One-cycle pulse
      s_axil_wready_o  <= aw_start;
      if (s_axil_awready_o) begin
        s_axil_bvalid_o <= 1'b1;
        if (aw_word == xcorr_pkg::REG_CTRL) begin
          enable_o <= s_axil_wdata_i[0];
        end else if (aw_word == xcorr_pkg::REG_ACC_LEN) begin
          acc_len_o <= s_axil_wdata_i;
        end
      end else if (s_axil_bvalid_o && s_axil_bready_i) begin
        s_axil_bvalid_o <= 1'b0;                // Response taken
      end
    end
  end

  // Read channel
  always_ff @(posedge app_clk) begin
    if (!rst_n_i) begin
      s_axil_arready_o <= 1'b0;
      s_axil_rvalid_o  <= 1'b0;
    end else begin
      s_axil_arready_o <= s_axil_arvalid_i && !s_axil_arready_o && !s_axil_rvalid_o;
      if (s_axil_arready_o) begin
        s_axil_rvalid_o <= 1'b1;
      end else if (s_axil_rvalid_o && s_axil_rready_i) begin
        s_axil_rvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge app_clk) begin
    if (s_axil_arready_o) begin
      s_axil_rdata_o <= rd_word;                // Held until rready
    end
  end

endmodule

// ==== hw/xcorr_top.sv ====
`timescale 1ns/1ns

module xcorr_top #(
  parameter int ACC_W = xcorr_pkg::ACC_W
) (
  input  logic                                app_clk,
  input  logic                                dsp_clk_i,  // 2x app_clk, edge-aligned
  input  logic                                rst_n_i,
  input  logic                                sample_valid_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0a_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0a_i_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1a_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1a_i_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0b_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in0b_i_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1b_r_i,
  input  logic signed [xcorr_pkg::SAMP_W-1:0] in1b_i_i,
  input  logic                                s_axil_awvalid_i,
  input  logic [xcorr_pkg::AXI_AW-1:0]        s_axil_awaddr_i,
  input  logic                                s_axil_wvalid_i,
  input  logic [xcorr_pkg::AXI_DW-1:0]        s_axil_wdata_i,
  input  logic                                s_axil_bready_i,
  output logic                                s_axil_awready_o,
  output logic                                s_axil_wready_o,
  output logic                                s_axil_bvalid_o,
  input  logic                                s_axil_arvalid_i,
  input  logic [xcorr_pkg::AXI_AW-1:0]        s_axil_araddr_i,
  input  logic                                s_axil_rready_i,
  output logic                                s_axil_arready_o,
  output logic                                s_axil_rvalid_o,
  output logic [xcorr_pkg::AXI_DW-1:0]        s_axil_rdata_o,
  output logic                                dump_o
);

  xprod_if prod_if ();                          // Products from multiplier

  logic                          last;          // Timer at final product
  logic                          count_en;
  logic                          clear;         // Idle clear for timer and sums
  logic                          acc_en;
  logic                          enable;
  logic [xcorr_pkg::AXI_DW-1:0]  acc_len;
  xcorr_pkg::vacc_state_e        state;
  logic [15:0]                   dump_cnt;
  logic signed [ACC_W-1:0]       bank [4];      // Latest dump

  cmult_conj_2x u_cmult (
    .app_clk, .dsp_clk_i, .rst_n_i, .sample_valid_i,
    .in0a_r_i, .in0a_i_i, .in1a_r_i, .in1a_i_i,
    .in0b_r_i, .in0b_i_i, .in1b_r_i, .in1b_i_i,
    .prod_o (prod_if)
  );

  acc_len_timer u_timer (
    .app_clk, .rst_n_i,
    .count_en_i (count_en), .clear_i (clear), .acc_len_i (acc_len), .last_o (last)
  );

  vacc_ctrl u_ctrl (
    .app_clk, .rst_n_i,
    .enable_i (enable), .prod_i (prod_if), .last_i (last),
    .count_en_o (count_en), .clear_o (clear), .acc_en_o (acc_en), .dump_o (dump_o),
    .state_o (state), .dump_cnt_o (dump_cnt)
  );

  vector_acc #(.ACC_W(ACC_W)) u_vacc (
    .app_clk, .rst_n_i,
    .prod_i (prod_if), .acc_en_i (acc_en), .dump_i (dump_o), .clr_i (clear),
    .bank_o (bank)
  );

  axil_csr #(.ACC_W(ACC_W)) u_csr (
    .app_clk, .rst_n_i,
    .s_axil_awvalid_i, .s_axil_awaddr_i, .s_axil_wvalid_i, .s_axil_wdata_i,
    .s_axil_bready_i, .s_axil_awready_o, .s_axil_wready_o, .s_axil_bvalid_o,
    .s_axil_arvalid_i, .s_axil_araddr_i, .s_axil_rready_i,
    .s_axil_arready_o, .s_axil_rvalid_o, .s_axil_rdata_o,
    .state_i (state), .dump_cnt_i (dump_cnt), .bank_i (bank),
    .enable_o (enable), .acc_len_o (acc_len)
  );

endmodule

// ==== verification/xcorr_tb.sv ====
`timescale 1ns/1ns

module xcorr_tb;

  localparam int ACC_W   = 48;
  localparam int NMAX    = 32;                  // Vector storage depth
  localparam int MAX_GAP = 3;                   // Longest idle gap between samples

  logic app_clk   = 1'b0;
  logic dsp_clk_i = 1'b1;                       // High at start so rising edges line up
  logic rst_n_i, sample_valid_i, dump_o;
  logic signed [17:0] in0a_r_i, in0a_i_i, in1a_r_i, in1a_i_i;
  logic signed [17:0] in0b_r_i, in0b_i_i, in1b_r_i, in1b_i_i;
  logic s_axil_awvalid_i, s_axil_wvalid_i, s_axil_bready_i, s_axil_arvalid_i, s_axil_rready_i;
  logic s_axil_awready_o, s_axil_wready_o, s_axil_bvalid_o, s_axil_arready_o, s_axil_rvalid_o;
  logic [7:0]  s_axil_awaddr_i, s_axil_araddr_i;
  logic [31:0] s_axil_wdata_i, s_axil_rdata_o;

  logic [17:0] samp_mem [NMAX][8];              // File columns 1 to 8
  logic [36:0] prod_mem [NMAX][4];              // File columns 9 to 12
  int nvec = 0, errors = 0, cycles = 0, limit = 0;
  int dumps_seen = 0;                           // dump_o pulses observed
  int dumps_exp  = 0;                           // Integrations the stimulus completed
  int seed = 32'hf617;
  logic [31:0] word;

  xcorr_top #(.ACC_W(ACC_W)) dut_i (.*);

  always #20 app_clk = ~app_clk;
  always #10 dsp_clk_i = ~dsp_clk_i;            // 2x, rises with every app_clk edge

  always @(negedge app_clk) begin
    if (dump_o === 1'b1) begin
      dumps_seen++;
    end
  end

  initial begin                                 // Watchdog
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge app_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, a handshake or dump never came", cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          rc;
    string       line;
    logic [17:0] s [8];
    logic [36:0] p [4];
    fd = $fopen("verification/xcorr_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/xcorr_vectors.txt");
      return;
    end
    while (!$feof(fd) && nvec < NMAX) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin  // Skip column notes
        rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                     s[0], s[1], s[2], s[3], s[4], s[5], s[6], s[7], p[0], p[1], p[2], p[3]);
        if (rc == 12) begin
          samp_mem[nvec] = s;
          prod_mem[nvec] = p;
          nvec++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data, input int stall);
    @(posedge app_clk);
    s_axil_awvalid_i <= 1'b1;
    s_axil_awaddr_i  <= addr;
    s_axil_wvalid_i  <= 1'b1;
    s_axil_wdata_i   <= data;
    do @(negedge app_clk); while (s_axil_awready_o !== 1'b1);
    check_value(64'(s_axil_wready_o), 64'd1, "wready not raised with awready");
    @(posedge app_clk);                         // Address and data taken here
    s_axil_awvalid_i <= 1'b0;
    s_axil_wvalid_i  <= 1'b0;
    do @(negedge app_clk); while (s_axil_bvalid_o !== 1'b1);
    repeat (stall) begin                        // bready held low
      @(negedge app_clk);
      check_value(64'(s_axil_bvalid_o), 64'd1, "bvalid dropped while bready low");
    end
    @(posedge app_clk);
    s_axil_bready_i <= 1'b1;
    @(posedge app_clk);
    s_axil_bready_i <= 1'b0;
  endtask

  task automatic axi_read(input logic [7:0] addr, input int stall, output logic [31:0] data);
    @(posedge app_clk);
    s_axil_arvalid_i <= 1'b1;
    s_axil_araddr_i  <= addr;
    do @(negedge app_clk); while (s_axil_arready_o !== 1'b1);
    @(posedge app_clk);
    s_axil_arvalid_i <= 1'b0;
    s_axil_araddr_i  <= addr ^ 8'h04;           // Address is free after the handshake
    do @(negedge app_clk); while (s_axil_rvalid_o !== 1'b1);
    data = s_axil_rdata_o;
    repeat (stall) begin                        // rready held low, data must not move
      @(negedge app_clk);
      check_value(64'(s_axil_rvalid_o), 64'd1, "rvalid dropped while rready low");
      check_value(64'(s_axil_rdata_o), 64'(data), "rdata changed while rready low");
    end
    @(posedge app_clk);
    s_axil_rready_i <= 1'b1;
    @(posedge app_clk);
    s_axil_rready_i <= 1'b0;
  endtask

  task automatic send_sample(input int idx);
    @(posedge app_clk);
    sample_valid_i <= 1'b1;
    in0a_r_i <= samp_mem[idx][0];
    in0a_i_i <= samp_mem[idx][1];
    in0b_r_i <= samp_mem[idx][2];
    in0b_i_i <= samp_mem[idx][3];
    in1a_r_i <= samp_mem[idx][4];
    in1a_i_i <= samp_mem[idx][5];
    in1b_r_i <= samp_mem[idx][6];
    in1b_i_i <= samp_mem[idx][7];
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge app_clk);
      sample_valid_i <= 1'b0;
    end
  endtask

  task automatic send_group(input int first, input int count, input bit gaps);
    int gap;
    for (int j = 0; j < count; j++) begin
      send_sample((first + j) % nvec);          // Indices wrap around the file
      gap = gaps ? int'($unsigned($random(seed)) % (MAX_GAP + 1)) : 0;
      idle_cycles(gap);
    end
    idle_cycles(1);
  endtask

  task automatic wait_dump();
    do @(negedge app_clk); while (dump_o !== 1'b1);
    @(posedge app_clk);                         // Bank loads on this edge
    dumps_exp++;
  endtask

  // Sums count products from first on, wraps at ACC_W, reads words low then high
  task automatic check_bank(input int first, input int count, input int max_stall);
    logic signed [ACC_W-1:0] sum;
    logic [63:0]             ext;
    logic [36:0]             prod;
    int                      stall;
    for (int k = 0; k < 8; k++) begin
      sum = '0;
      for (int j = 0; j < count; j++) begin
        prod = prod_mem[(first + j) % nvec][k / 2];
        sum  = sum + {{(ACC_W-37){prod[36]}}, prod};
      end
      ext   = {{(64-ACC_W){sum[ACC_W-1]}}, sum};
      stall = (max_stall > 0) ? int'($unsigned($random(seed)) % max_stall) + 1 : 0;
      axi_read(xcorr_pkg::REG_RES_BASE + 8'(4 * k), stall, word);
      check_value(64'(word), (k % 2 == 1) ? 64'(ext[63:32]) : 64'(ext[31:0]),
                  $sformatf("result word %0d, group from vector %0d", k, first));
    end
  endtask

  task automatic check_status(input logic [1:0] state, input int count);
    axi_read(xcorr_pkg::REG_STATUS, 0, word);
    check_value(64'(word[1:0]), 64'(state), "status state");
    check_value(64'(word[31:16]), 64'(count[15:0]), "status dump count");
  endtask

  initial begin
    rst_n_i = 1'b0;
    sample_valid_i = 1'b0;
    {in0a_r_i, in0a_i_i, in1a_r_i, in1a_i_i, in0b_r_i, in0b_i_i, in1b_r_i, in1b_i_i} = '0;
    {s_axil_awvalid_i, s_axil_wvalid_i, s_axil_bready_i, s_axil_arvalid_i} = '0;
    {s_axil_rready_i, s_axil_awaddr_i, s_axil_araddr_i, s_axil_wdata_i} = '0;
    load_vectors();
    limit = 20 * nvec * (MAX_GAP + 1) + 500;    // Vectors plus worst gaps, scaled
    repeat (4) @(posedge app_clk);
    rst_n_i <= 1'b1;
    if (nvec < 16) begin
      $display("Vector file missing or short, %0d lines read", nvec);
      errors++;
    end else begin
      axi_read(xcorr_pkg::REG_CTRL, 0, word);   // Reset values
      check_value(64'(word), 64'd0, "CTRL after reset");
      axi_read(xcorr_pkg::REG_ACC_LEN, 0, word);
      check_value(64'(word), 64'd4, "ACC_LEN after reset");
      check_status(xcorr_pkg::IDLE, 0);
      check_value(64'(dumps_seen), 64'd0, "dump_o pulsed while idle");
      axi_write(xcorr_pkg::REG_ACC_LEN, 32'd1, 0);  // One product per dump
      axi_write(xcorr_pkg::REG_CTRL, 32'd1, 0);
      for (int v = 0; v < 4; v++) begin
        send_group(v, 1, 1'b0);
        wait_dump();
        check_bank(v, 1, 0);
      end
      axi_write(xcorr_pkg::REG_CTRL, 32'd0, 0);     // Four per dump, random gaps
      axi_write(xcorr_pkg::REG_ACC_LEN, 32'd4, 0);
      axi_write(xcorr_pkg::REG_CTRL, 32'd1, 0);
      for (int g = 0; g < 2; g++) begin
        send_group(4 + 4 * g, 4, 1'b1);
        wait_dump();
        check_bank(4 + 4 * g, 4, 0);
      end
      check_status(xcorr_pkg::ACCUM, dumps_exp);
      check_value(64'(dumps_seen), 64'(dumps_exp), "dump_o pulse count");
      send_group(12, 2, 1'b0);                  // Partial integration, then disable
      idle_cycles(6);
      axi_write(xcorr_pkg::REG_CTRL, 32'd0, 0);
      check_status(xcorr_pkg::IDLE, dumps_exp);
      axi_write(xcorr_pkg::REG_CTRL, 32'd1, 0);
      send_group(14, 4, 1'b1);                  // Only these four count
      wait_dump();
      check_bank(14, 4, 0);
      check_status(xcorr_pkg::ACCUM, dumps_exp);
      check_bank(14, 4, 8);                     // Same bank under AXI back-pressure
      axi_write(xcorr_pkg::REG_ACC_LEN, 32'd7, int'($unsigned($random(seed)) % 8) + 1);
      axi_read(xcorr_pkg::REG_ACC_LEN, int'($unsigned($random(seed)) % 8) + 1, word);
      check_value(64'(word), 64'd7, "ACC_LEN after stalled write");
      check_value(64'(dumps_seen), 64'(dumps_exp), "dump_o pulse count at end");
    end
    $display("Errors: %0d, dumps: %0d, cycles: %0d", errors, dumps_seen, cycles);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verification/xcorr_vectors.txt ====
# a0_r a0_i b0_r b0_i a1_r a1_i b1_r b1_i, 18-bit two's complement hex, then
# p0_r p0_i p1_r p1_i, 37-bit hex of a times conj(b) for slot 0 and slot 1
00003 00004 00002 00001 00001 00000 00000 00001 000000000a 0000000005 0000000000 1fffffffff
3ffff 00002 00005 3fffd 00007 00007 3fffe 3fffe 1ffffffff5 0000000007 1fffffffe4 0000000000
00064 3ffce 00014 0001e 3fff8 00009 00006 3fffc 00000001f4 1ffffff060 1fffffffac 0000000016
1ffff 00000 1ffff 00000 00000 20000 00000 20000 03fffc0001 0000000000 0400000000 0000000000
00001 00001 00001 00001 00002 00003 00004 00005 0000000002 0000000000 0000000017 0000000002
3fffd 3fffd 00003 3fffd 0000a 00000 00000 0000a 0000000000 1fffffffee 0000000000 1fffffff9c
003e8 007d0 3fc18 001f4 3ffff 3ffff 3ffff 3ffff 0000000000 1fffd9da60 0000000002 0000000000
00000 00005 00000 3fffb 0000c 3fff9 00003 00002 1fffffffe7 0000000000 0000000016 1fffffffd3
00002 00000 00000 00003 3fffa 00004 00005 00005 0000000000 1ffffffffa 1ffffffff6 0000000032
00009 00009 00009 3fff7 00000 00000 00007 00008 0000000000 00000000a2 0000000000 0000000000
3ff9c 00000 3ff9c 00000 00032 0003c 3ffba 00050 0000002710 0000000000 0000000514 1fffffdff8
00004 3fffc 3fffc 00004 00001 00002 00003 00004 1fffffffe0 0000000000 000000000b 0000000002
0000f 00000 00001 00001 00000 0000f 00001 00001 000000000f 1ffffffff1 000000000f 000000000f
3ffec 0000a 00003 3ffff 00008 00008 00008 00008 1fffffffba 000000000a 0000000080 0000000000
12345 3ffb3 00002 00000 00000 00001 10000 00000 000002468a 1fffffff66 0000000000 0000010000
00006 3fffe 00001 00001 3fff7 3fff7 00002 3fffd 0000000004 1ffffffff8 0000000009 1fffffffd3

// ==== xcorr.f ====
hw/xcorr_pkg.sv
hw/xprod_if.sv
hw/cmult_conj_2x.sv
hw/acc_len_timer.sv
hw/vacc_ctrl.sv
hw/vector_acc.sv
hw/axil_csr.sv
hw/xcorr_top.sv
verification/xcorr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds xcorr_tb with Verilator, runs it from the project root and checks the log
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --top-module xcorr_tb -f xcorr.f -o xcorr_sim \
  && ./obj_dir/xcorr_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }
cat sim.log
grep -q "PASS: all tests" sim.log || { echo "Simulation reported failure"; exit 1; }
